//--- hdl/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// 8-way set associative, 64 sets
`define ICACHE_WAYS 8
`define ICACHE_SETS 64

// one line is 8 doublewords of 64 bits
`define ICACHE_DATA_PER_LINE 8

// 32-bit bus beats needed to fill one line
`define ICACHE_WORDS_PER_LINE 16

// bytes per doubleword and per bus word
`define ICACHE_BYTES_PER_DATA 8
`define ICACHE_BYTES_PER_WORD 4

`endif

//--- hdl/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

    typedef logic [$clog2(`ICACHE_SETS)-1:0]           index_t;
    typedef logic [$clog2(`ICACHE_DATA_PER_LINE)-1:0]  offset_t;
    typedef logic [$clog2(`ICACHE_BYTES_PER_DATA)-1:0] align_t;
    typedef logic [31-$bits(index_t)-$bits(offset_t)-$bits(align_t):0] tag_t;

    typedef logic [8*`ICACHE_BYTES_PER_WORD-1:0] word_t;
    typedef logic [8*`ICACHE_BYTES_PER_DATA-1:0] data_t;

    typedef logic [$clog2(`ICACHE_WAYS)-1:0]           way_t;
    typedef logic [`ICACHE_WAYS-2:0]                   plru_t;
    typedef logic [$clog2(`ICACHE_WORDS_PER_LINE)-1:0] beat_t;
    typedef logic [`ICACHE_WORDS_PER_LINE-1:0]         fill_mask_t;
    typedef logic [1:0]                                word_strobe_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
        align_t  align;
    } addr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        data_t data;
    } ibus_resp_t;

    // burst length is fixed at one full line
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    typedef enum logic {
        IDLE,
        FETCH
    } fill_state_t;

endpackage

//--- hdl/icache_tag_array.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_tag_array (
    input  logic               clk,
    input  icache_pkg::index_t index,
    input  icache_pkg::tag_t   tag,
    input  logic               alloc,
    input  icache_pkg::way_t   alloc_way,
    output logic               hit,
    output icache_pkg::way_t   hit_way
);

    import icache_pkg::*;

    meta_t meta_mem [`ICACHE_SETS][`ICACHE_WAYS];
    meta_t set_meta [`ICACHE_WAYS];

    // combinational read of the whole set
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            set_meta[w] = meta_mem[index][w];
        end
    end

    // scan downwards so the lowest matching way wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (set_meta[w].valid && set_meta[w].tag == tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // new line claims the victim way at the miss
    always_ff @(posedge clk) begin
        if (alloc) begin
            meta_mem[index][alloc_way] <= '{valid: 1'b1, tag: tag};
        end
    end

endmodule

//--- hdl/icache_plru.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_plru (
    input  logic               clk,
    input  logic               resetn,
    input  icache_pkg::index_t index,
    input  logic               touch,
    input  icache_pkg::way_t   touch_way,
    output icache_pkg::way_t   victim
);

    import icache_pkg::*;

    plru_t plru_mem [`ICACHE_SETS];
    plru_t cur_tree;
    plru_t next_tree;

    assign cur_tree = plru_mem[index];

    // node 0 is the root, children of node n are 2n+1 and 2n+2
    // a 0 bit sends the walk left
    always_comb begin
        victim    = '0;
        victim[2] = cur_tree[0];
        victim[1] = victim[2] ? cur_tree[2] : cur_tree[1];
        victim[0] = cur_tree[3 + victim[2:1]];
    end

    // point every node on the path away from the touched way
    always_comb begin
        next_tree                    = cur_tree;
        next_tree[0]                 = ~touch_way[2];
        next_tree[1 + touch_way[2]]   = ~touch_way[1];
        next_tree[3 + touch_way[2:1]] = ~touch_way[0];
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                plru_mem[s] <= '0;
            end
        end else if (touch) begin
            plru_mem[index] <= next_tree;
        end
    end

endmodule

//--- hdl/icache_data_array.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_data_array (
    input  logic                     clk,
    input  logic                     rd_en,
    input  icache_pkg::way_t         rd_way,
    input  icache_pkg::index_t       rd_index,
    input  icache_pkg::offset_t      rd_offset,
    output icache_pkg::data_t        rd_data,
    input  icache_pkg::word_strobe_t wr_strobe,
    input  icache_pkg::way_t         wr_way,
    input  icache_pkg::index_t       wr_index,
    input  icache_pkg::offset_t      wr_offset,
    input  icache_pkg::word_t        wr_word
);

    import icache_pkg::*;

    localparam int DEPTH = `ICACHE_WAYS * `ICACHE_SETS * `ICACHE_DATA_PER_LINE;
    localparam int WW    = $bits(word_t);

    data_t data_mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] rd_addr;
    logic [$clog2(DEPTH)-1:0] wr_addr;

    assign rd_addr = {rd_way, rd_index, rd_offset};
    assign wr_addr = {wr_way, wr_index, wr_offset};

    // read data holds until the next enabled read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= data_mem[rd_addr];
        end
        if (wr_strobe[0]) begin
            data_mem[wr_addr][WW-1:0] <= wr_word;
        end
        if (wr_strobe[1]) begin
            data_mem[wr_addr][2*WW-1:WW] <= wr_word;
        end
    end

endmodule

//--- hdl/icache_refill_ctrl.sv
`timescale 1ns/10ps

module icache_refill_ctrl (
    input  logic                     clk,
    input  logic                     resetn,
    input  icache_pkg::ibus_req_t    ireq,
    input  icache_pkg::cbus_resp_t   icresp,
    input  logic                     hit,
    input  icache_pkg::way_t         hit_way,
    input  icache_pkg::way_t         victim,
    output logic                     iresp_ok,
    output logic                     data_ok,
    output logic                     alloc,
    output logic                     touch,
    output icache_pkg::word_strobe_t wr_strobe,
    output icache_pkg::way_t         wr_way,
    output icache_pkg::index_t       wr_index,
    output icache_pkg::offset_t      wr_offset,
    output icache_pkg::cbus_req_t    icreq
);

    import icache_pkg::*;

    fill_state_t state;
    addr_t       fill_addr;
    way_t        fill_way;
    offset_t     fill_offset;
    beat_t       beat;
    fill_mask_t  fill_mask;

    logic beat_fire;
    logic other_line;
    logic dword_ready;
    logic hit_avail;

    assign beat_fire = (state == FETCH) && icresp.ready;

    // the fill way already carries the new tag, so way and index name the line
    assign other_line  = {hit_way, ireq.addr.index} != {fill_way, fill_addr.index};
    assign dword_ready = fill_mask[{ireq.addr.offset, 1'b0}]
                      && fill_mask[{ireq.addr.offset, 1'b1}];
    assign hit_avail   = (state == IDLE) || other_line || dword_ready;

    assign touch    = ireq.valid && hit && hit_avail;
    assign alloc    = ireq.valid && !hit && (state == IDLE);
    assign iresp_ok = touch;

    // even beats fill the low half, odd beats the high half
    assign wr_strobe = beat_fire ? (beat[0] ? 2'b10 : 2'b01) : 2'b00;
    assign wr_way    = fill_way;
    assign wr_index  = fill_addr.index;
    assign wr_offset = fill_offset;

    assign icreq = '{valid: (state == FETCH), addr: fill_addr};

    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= IDLE;
            data_ok <= 1'b0;
        end else begin
            data_ok <= touch;
            unique case (state)
                IDLE: begin
                    if (alloc) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (beat_fire && icresp.last) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // critical word first, beat count wraps inside the line
    always_ff @(posedge clk) begin
        if (alloc) begin
            fill_addr   <= ireq.addr;
            fill_way    <= victim;
            fill_offset <= ireq.addr.offset;
            beat        <= {ireq.addr.offset, ireq.addr.align[2]};
            fill_mask   <= '0;
        end else if (beat_fire) begin
            beat            <= beat + 1'b1;
            fill_mask[beat] <= 1'b1;
            if (beat[0]) begin
                fill_offset <= fill_offset + 1'b1;
            end
        end
    end

endmodule

//--- hdl/icache_top.sv
`timescale 1ns/10ps

module icache_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  icache_pkg::ibus_req_t  ireq,
    output icache_pkg::ibus_resp_t iresp,
    output icache_pkg::cbus_req_t  icreq,
    input  icache_pkg::cbus_resp_t icresp
);

    import icache_pkg::*;

    logic         hit;
    way_t         hit_way;
    way_t         victim;
    logic         alloc;
    logic         touch;
    logic         addr_ok;
    logic         data_ok;
    word_strobe_t wr_strobe;
    way_t         wr_way;
    index_t       wr_index;
    offset_t      wr_offset;
    data_t        rd_data;

    icache_tag_array u_tag (
        .clk       (clk),
        .index     (ireq.addr.index),
        .tag       (ireq.addr.tag),
        .alloc     (alloc),
        .alloc_way (victim),
        .hit       (hit),
        .hit_way   (hit_way)
    );

    icache_plru u_plru (
        .clk       (clk),
        .resetn    (resetn),
        .index     (ireq.addr.index),
        .touch     (touch),
        .touch_way (hit_way),
        .victim    (victim)
    );

    // port 1 serves hits, port 2 takes the fill beats
    icache_data_array u_data (
        .clk       (clk),
        .rd_en     (touch),
        .rd_way    (hit_way),
        .rd_index  (ireq.addr.index),
        .rd_offset (ireq.addr.offset),
        .rd_data   (rd_data),
        .wr_strobe (wr_strobe),
        .wr_way    (wr_way),
        .wr_index  (wr_index),
        .wr_offset (wr_offset),
        .wr_word   (icresp.data)
    );

    icache_refill_ctrl u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .ireq      (ireq),
        .icresp    (icresp),
        .hit       (hit),
        .hit_way   (hit_way),
        .victim    (victim),
        .iresp_ok  (addr_ok),
        .data_ok   (data_ok),
        .alloc     (alloc),
        .touch     (touch),
        .wr_strobe (wr_strobe),
        .wr_way    (wr_way),
        .wr_index  (wr_index),
        .wr_offset (wr_offset),
        .icreq     (icreq)
    );

    assign iresp = '{addr_ok: addr_ok, data_ok: data_ok, data: rd_data};

endmodule

//--- dv/icache_assertions.sv
`timescale 1ns/10ps

module icache_assertions (
    input logic                   clk,
    input logic                   resetn,
    input icache_pkg::ibus_resp_t iresp,
    input icache_pkg::cbus_req_t  icreq,
    input icache_pkg::cbus_resp_t icresp
);

    logic [4:0] beat_cnt;
    int         fail_count = 0;

    // beats taken in the current fill
    always_ff @(posedge clk) begin
        if (resetn || !icreq.valid) begin
            beat_cnt <= '0;
        end else if (icresp.ready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    a_data_follows: assert property (@(posedge clk) disable iff (resetn)
        iresp.data_ok == $past(iresp.addr_ok))
        else begin
            $error("data_ok is not one cycle after addr_ok");
            fail_count++;
        end

    a_req_stable: assert property (@(posedge clk) disable iff (resetn)
        icreq.valid && !(icresp.ready && icresp.last) |=> icreq.valid && $stable(icreq.addr))
        else begin
            $error("icreq dropped or changed before the last beat");
            fail_count++;
        end

    a_fill_len: assert property (@(posedge clk) disable iff (resetn)
        icreq.valid && icresp.ready |-> beat_cnt < 16)
        else begin
            $error("fill took more than 16 beats");
            fail_count++;
        end

    a_fill_end: assert property (@(posedge clk) disable iff (resetn)
        icreq.valid && icresp.ready && icresp.last |=> !icreq.valid)
        else begin
            $error("icreq still valid after the last beat");
            fail_count++;
        end

endmodule

bind icache_top icache_assertions u_assert (
    .clk    (clk),
    .resetn (resetn),
    .iresp  (iresp),
    .icreq  (icreq),
    .icresp (icresp)
);

//--- dv/icache_tb.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_tb;

    import icache_pkg::*;

    localparam int    NUM_TABLE    = 48;
    localparam int    NUM_DIRECTED = 12;
    localparam word_t SALT         = 32'h5a5a_0000;
    localparam addr_t LINE_A       = 32'h0001_235c;
    localparam addr_t LINE_B       = 32'h0004_7a80;

    logic       clk = 1'b0;
    logic       resetn;
    ibus_req_t  ireq;
    ibus_resp_t iresp;
    cbus_req_t  icreq;
    cbus_resp_t icresp;

    integer seed      = 32'h7289_9d6b;
    logic   mem_busy  = 1'b0;
    logic   mem_stall = 1'b0;
    int     beats     = 0;
    addr_t  mem_base;
    addr_t  table_addr [NUM_TABLE];
    logic   table_miss [NUM_TABLE];
    logic   mdl_valid [`ICACHE_SETS][`ICACHE_WAYS];
    tag_t   mdl_tag [`ICACHE_SETS][`ICACHE_WAYS];
    plru_t  mdl_tree [`ICACHE_SETS];

    icache_top dut (
        .clk    (clk),
        .resetn (resetn),
        .ireq   (ireq),
        .iresp  (iresp),
        .icreq  (icreq),
        .icresp (icresp)
    );

    always #20 clk = ~clk;

    task automatic fail_stop(string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic compare_data(string name, data_t exp, data_t got);
        if (got !== exp) begin
            fail_stop($sformatf("Error at %0t: %s expected %h, got %h",
                                $time, name, exp, got));
        end
    endtask

    task automatic verify_addr(string name, addr_t exp, addr_t got);
        if (got !== exp) begin
            fail_stop($sformatf("Error at %0t: %s expected %h, got %h",
                                $time, name, exp, got));
        end
    endtask

    task automatic expect_bit(string name, logic exp, logic got);
        if (got !== exp) begin
            fail_stop($sformatf("Error at %0t: %s expected %b, got %b",
                                $time, name, exp, got));
        end
    endtask

    // burst memory, each word is its own byte address xor the salt
    always @(negedge clk) begin
        if (mem_busy && icresp.ready) begin
            beats = beats + 1;
            if (icresp.last) begin
                mem_busy = 1'b0;
                if (icreq.valid) begin
                    fail_stop("fill request still valid after the last beat");
                end
            end
        end
        if (!mem_busy && icreq.valid) begin
            mem_busy = 1'b1;
            beats    = 0;
            mem_base = icreq.addr;
        end
        icresp.ready = mem_busy && !mem_stall && (($random(seed) & 3) != 0);
        icresp.last  = mem_busy && (beats == `ICACHE_WORDS_PER_LINE - 1);
        icresp.data  = {mem_base[31:6], mem_base[5:2] + beat_t'(beats), 2'b00} ^ SALT;
    end

    function automatic data_t dword_of(addr_t a);
        word_t lo = {a[31:3], 3'b000} ^ SALT;
        word_t hi = {a[31:3], 3'b100} ^ SALT;
        return {hi, lo};
    endfunction

    // walk down from the root, a 0 bit goes left
    function automatic way_t plru_pick(plru_t t);
        int n = 0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            n = 2 * n + 1 + t[n];
        end
        return way_t'(n - 7);
    endfunction

    function automatic plru_t plru_update(plru_t t, way_t w);
        int n = 0;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            t[n] = ~w[lvl];
            n    = 2 * n + 1 + w[lvl];
        end
        return t;
    endfunction

    function automatic logic predict_miss(addr_t a);
        logic miss = 1'b1;
        way_t way  = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (miss && mdl_valid[a.index][w] && mdl_tag[a.index][w] == a.tag) begin
                miss = 1'b0;
                way  = way_t'(w);
            end
        end
        if (miss) begin
            way                     = plru_pick(mdl_tree[a.index]);
            mdl_valid[a.index][way] = 1'b1;
            mdl_tag[a.index][way]   = a.tag;
        end
        // the retry after a miss is a hit on the new way
        mdl_tree[a.index] = plru_update(mdl_tree[a.index], way);
        return miss;
    endfunction

    task automatic wait_fill_end();
        while (icreq.valid) begin
            @(posedge clk);
        end
        if (beats != `ICACHE_WORDS_PER_LINE) begin
            fail_stop("fill did not deliver exactly 16 words");
        end
    endtask

    task automatic fetch_once(addr_t a, logic exp_miss);
        logic missed = 1'b0;
        @(negedge clk);
        ireq = '{valid: 1'b1, addr: a};
        do begin
            @(posedge clk);
            missed |= icreq.valid;
        end while (!iresp.addr_ok);
        @(negedge clk);
        ireq.valid = 1'b0;
        @(posedge clk);
        expect_bit("iresp.data_ok", 1'b1, iresp.data_ok);
        compare_data("iresp.data", dword_of(a), iresp.data);
        expect_bit("icreq.valid rise", exp_miss, missed);
        if (missed) begin
            verify_addr("icreq.addr", a, mem_base);
            wait_fill_end();
        end
    endtask

    // one request per cycle, data checked one cycle behind
    task automatic hit_burst(addr_t first, int count);
        addr_t a = first;
        addr_t prev;
        for (int i = 0; i <= count; i++) begin
            @(negedge clk);
            ireq = '{valid: (i < count), addr: a};
            @(posedge clk);
            if (i > 0) begin
                expect_bit("iresp.data_ok", 1'b1, iresp.data_ok);
                compare_data("iresp.data", dword_of(prev), iresp.data);
            end
            if (i < count) begin
                expect_bit("iresp.addr_ok", !predict_miss(a), iresp.addr_ok);
            end
            prev     = a;
            a.offset = a.offset + 1'b1;
        end
    endtask

    initial begin
        repeat ((NUM_TABLE + NUM_DIRECTED) * 40 + 8) @(posedge clk);
        fail_stop("timeout, the run went past its cycle budget");
    end

    initial begin
        logic        done;
        logic [31:0] rnd;
        resetn = 1'b1;
        ireq   = '0;
        icresp = '0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            mdl_tree[s] = '0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                mdl_valid[s][w] = 1'b0;
            end
        end
        repeat (8) @(negedge clk);
        resetn = 1'b0;
        @(posedge clk);
        expect_bit("iresp.addr_ok", 1'b0, iresp.addr_ok);
        expect_bit("iresp.data_ok", 1'b0, iresp.data_ok);
        expect_bit("icreq.valid", 1'b0, icreq.valid);

        // odd critical word, then the whole line back to back
        fetch_once(LINE_A, predict_miss(LINE_A));
        hit_burst(LINE_A, `ICACHE_DATA_PER_LINE);

        // stalled fill of line B while line A keeps hitting
        mem_stall = 1'b1;
        @(negedge clk);
        ireq = '{valid: 1'b1, addr: LINE_B};
        repeat (2) @(posedge clk);
        expect_bit("icreq.valid", predict_miss(LINE_B), icreq.valid);
        verify_addr("icreq.addr", LINE_B, icreq.addr);
        @(negedge clk);
        ireq.addr = LINE_A;
        @(posedge clk);
        expect_bit("iresp.addr_ok", !predict_miss(LINE_A), iresp.addr_ok);
        @(negedge clk);
        ireq.addr = LINE_B;
        @(posedge clk);
        compare_data("iresp.data", dword_of(LINE_A), iresp.data);
        repeat (4) begin
            expect_bit("iresp.addr_ok", 1'b0, iresp.addr_ok);
            @(posedge clk);
        end
        mem_stall = 1'b0;
        done      = 1'b0;
        while (!done) begin
            @(posedge clk);
            expect_bit("iresp.addr_ok", beats >= 2, iresp.addr_ok);
            done = iresp.addr_ok;
        end
        void'(predict_miss(LINE_B));
        @(negedge clk);
        ireq.valid = 1'b0;
        @(posedge clk);
        expect_bit("iresp.data_ok", 1'b1, iresp.data_ok);
        compare_data("iresp.data", dword_of(LINE_B), iresp.data);
        wait_fill_end();

        // nine tags in set 5 twice over, then random lines in sets 0 to 7
        for (int i = 0; i < NUM_TABLE; i++) begin
            rnd = $random(seed);
            if (i < 18) begin
                table_addr[i] = {20'h0a000 + 20'(i % 9), 6'd5, 3'(i % 8), 3'b000};
            end else begin
                table_addr[i] = {20'h00100 + 20'(rnd[6:3]), 3'b000, rnd[2:0], rnd[12:7]};
            end
            table_miss[i] = predict_miss(table_addr[i]);
        end
        for (int i = 0; i < NUM_TABLE; i++) begin
            fetch_once(table_addr[i], table_miss[i]);
        end

        if (dut.u_assert.fail_count != 0) begin
            fail_stop("protocol assertions failed during the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_tag_array.sv
hdl/icache_plru.sv
hdl/icache_data_array.sv
hdl/icache_refill_ctrl.sv
hdl/icache_top.sv
dv/icache_assertions.sv
dv/icache_tb.sv
